//--- filelist.f
+incdir+test
logic/mem_pkg.sv
logic/reset_sequencer.sv
logic/port_arbiter.sv
logic/bank_access.sv
logic/done_return.sv
logic/memory_subsystem_top.sv
test/tb_memory_subsystem.sv

//--- Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -j 0
TOP       ?= tb_memory_subsystem
FILELIST  ?= filelist.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
PASS_MSG  := sim passed

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run, pass only if the log holds the pass line"
	@echo "  clean  remove build output and the log"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -o $(TOP) -f $(FILELIST)
	./$(OBJ_DIR)/$(TOP) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@grep -qx "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

//--- test/tb_checks.svh
// error counters and concurrent checks for reset, calibration, data, latency, pulses and races

int value_errors = 0;      // wrong data or wrong cycle counts
int protocol_errors = 0;   // handshake rule broken
int timing_errors = 0;
int timeout_errors = 0;    // a request never answered

////////////////////////////////////////
// reset and calibration
////////////////////////////////////////

// one cycle for mem_reset to take hold, then everything must be quiet
reset_quiet_a: assert property (@(posedge main_clk) reset && $past(reset) |=>
   done_v == 3'b000 && !sdram_ready && !vram_cpu_ready && !calib_done &&
   sdram_data_out == '0 && vram_cpu_data_out == '0 && vram_vga_data_out == '0)
   else begin
      protocol_errors++;
      $display("%0t outputs not cleared while reset is held", $time);
   end

calib_time_a: assert property (@(posedge main_clk)
   $rose(calib_done) |-> since_reset == calib_cycles + stretch_cycles)
   else begin
      timing_errors++;
      $display("[FAIL] %0t calib_done rise cycle expected %0d got %0d", $time,
         calib_cycles + stretch_cycles, $sampled(since_reset));
   end

ready_calib_a: assert property (@(posedge main_clk)
   !calib_done |-> !sdram_ready && !vram_cpu_ready)
   else begin
      protocol_errors++;
      $display("%0t a ready came up before calibration finished", $time);
   end

////////////////////////////////////////
// per port
////////////////////////////////////////

for (genvar p = 0; p < 3; p++) begin : g_port
   // reads only, and only where the reference knows the word
   data_a: assert property (@(posedge main_clk) disable iff (reset)
      done_v[p] && !wr_v[p] && known_v[p] |-> data_v[p] == exp_v[p])
      else begin
         value_errors++;
         $display("[FAIL] %0t %s_data_out expected %h got %h", $time, port_name(p),
            $sampled(exp_v[p]), $sampled(data_v[p]));
      end

   latency_a: assert property (@(posedge main_clk) disable iff (reset)
      !race_mode && done_v[p] |-> lat_v[p] == access_lat + 2)
      else begin
         timing_errors++;
         $display("[FAIL] %0t %s done latency expected %0d got %0d", $time, port_name(p),
            access_lat + 2, $sampled(lat_v[p]));
      end

   // one cycle wide, inside an open request, once per request
   pulse_a: assert property (@(posedge main_clk) disable iff (reset)
      done_v[p] |-> req_v[p] && busy_v[p] ##1 !done_v[p])
      else begin
         protocol_errors++;
         $display("%0t %s done pulse too long, extra or outside its request", $time,
            port_name(p));
      end
end

////////////////////////////////////////
// three-way race
////////////////////////////////////////

race_order_a: assert property (@(posedge main_clk) disable iff (reset)
   race_mode && (sdram_done || vram_cpu_done) |-> race_seen[2] &&
   (!vram_cpu_done || race_seen[0]))
   else begin
      protocol_errors++;
      $display("%0t race finished out of order, display then sdram then vram_cpu", $time);
   end

// back to back completions only if the pipeline held all three at once
race_overlap_a: assert property (@(posedge main_clk) disable iff (reset)
   race_mode && (vram_vga_ready || sdram_done) |=> (sdram_done || vram_cpu_done))
   else begin
      protocol_errors++;
      $display("%0t race completions not back to back, accesses did not overlap", $time);
   end

//--- test/tb_memory_subsystem.sv
// testbench top, clock, reset, client stimulus, reference stores and watchdog
`timescale 1ns/1ns

module tb_memory_subsystem import mem_pkg::*; ();

   localparam int sdram_aw = 12;
   localparam int vram_aw = 10;
   localparam int access_lat = 3;
   localparam int calib_cycles = 64;
   localparam int stretch_cycles = 4;          // mem_reset tail after board reset
   localparam int n_rand = 16;                 // sdram writes, then as many reads
   localparam int n_video = 4;                 // write, display read, cpu read each
   localparam int n_race = 2;
   localparam int n_accesses = 2 * n_rand + 3 * n_video + 3 * n_race;
   localparam int watchdog_cycles = 8 + calib_cycles + n_accesses * (access_lat + 6) + 100;
   localparam int done_limit = 4 * (access_lat + 2);   // per access
   localparam logic [31:0] rand_seed = 32'h424a_8c6e;

   logic main_clk, reset, calib_done;
   logic sdram_req, sdram_write, sdram_ready, sdram_done;
   logic [sdram_aw-1:0] sdram_addr;
   logic [data_w-1:0] sdram_data_in, sdram_data_out;
   logic vram_cpu_req, vram_cpu_write, vram_cpu_ready, vram_cpu_done;
   logic [vram_aw-1:0] vram_cpu_addr;
   logic [data_w-1:0] vram_cpu_data_in, vram_cpu_data_out;
   logic vram_vga_req, vram_vga_ready;
   logic [vram_aw-1:0] vram_vga_addr;
   logic [data_w-1:0] vram_vga_data_out;

   // reference stores updated when a write's done comes back
   logic [data_w-1:0] ref_main [2**sdram_aw];
   logic [data_w-1:0] ref_video [2**vram_aw];
   logic [2**sdram_aw-1:0] known_main;
   logic [2**vram_aw-1:0] known_video;

   // per-port views indexed 0 sdram 1 vram_cpu 2 vram_vga
   logic [2:0] req_v, rdy_v, done_v, wr_v, known_v, accept_v, busy_v, race_seen;
   logic [data_w-1:0] data_v [3];
   logic [data_w-1:0] exp_v [3];
   int lat_v [3];                              // cycles since accept
   int since_reset;
   logic race_mode;                            // all three ports launched together

   memory_subsystem_top #(.SDRAM_AW(sdram_aw), .VRAM_AW(vram_aw), .ACCESS_LAT(access_lat),
      .CALIB_CYCLES(calib_cycles)) dut_i (.*);

   always #2 main_clk = ~main_clk;

   assign req_v = {vram_vga_req, vram_cpu_req, sdram_req};
   assign rdy_v = {calib_done, vram_cpu_ready, sdram_ready};   // display has no ready of its own
   assign done_v = {vram_vga_ready, vram_cpu_done, sdram_done};
   assign wr_v = {1'b0, vram_cpu_write, sdram_write};
   assign accept_v = req_v & rdy_v & ~busy_v;
   assign data_v = '{sdram_data_out, vram_cpu_data_out, vram_vga_data_out};
   assign exp_v = '{ref_main[sdram_addr], ref_video[vram_cpu_addr], ref_video[vram_vga_addr]};
   assign known_v = {known_video[vram_vga_addr], known_video[vram_cpu_addr],
      known_main[sdram_addr]};

   function automatic string port_name(input int p);
      case (p)
         0: return "sdram";
         1: return "vram_cpu";
         default: return "vram_vga";
      endcase
   endfunction

   `include "tb_checks.svh"

   ////////////////////////////////////////
   // reference model and request tracking
   ////////////////////////////////////////

   always @(posedge main_clk) begin
      if (reset) begin
         known_main <= '0;
         known_video <= '0;
      end else begin
         if (sdram_done && sdram_write) begin
            ref_main[sdram_addr] <= sdram_data_in;
            known_main[sdram_addr] <= 1'b1;
         end
         if (vram_cpu_done && vram_cpu_write) begin
            ref_video[vram_cpu_addr] <= vram_cpu_data_in;
            known_video[vram_cpu_addr] <= 1'b1;
         end
      end
   end

   always @(posedge main_clk) begin
      for (int p = 0; p < 3; p++) begin
         if (reset) begin
            busy_v[p] <= 1'b0;
         end else if (accept_v[p]) begin
            busy_v[p] <= 1'b1;                // open until its done
            lat_v[p] <= 1;
         end else if (busy_v[p]) begin
            lat_v[p] <= lat_v[p] + 1;
            busy_v[p] <= !done_v[p];
         end
      end
      race_seen <= race_mode ? (race_seen | done_v) : 3'b000;
      since_reset <= reset ? 0 : since_reset + 1;
   end

   ////////////////////////////////////////
   // stimulus
   ////////////////////////////////////////

   task automatic drive_port(input int p, input logic active, input logic wr, input int addr,
         input logic [data_w-1:0] wdata);
      case (p)
         0: begin
            sdram_req = active;
            sdram_write = wr;
            sdram_addr = sdram_aw'(addr);
            sdram_data_in = wdata;
         end
         1: begin
            vram_cpu_req = active;
            vram_cpu_write = wr;
            vram_cpu_addr = vram_aw'(addr);
            vram_cpu_data_in = wdata;
         end
         default: begin
            vram_vga_req = active;              // reads only
            vram_vga_addr = vram_aw'(addr);
         end
      endcase
   endtask

   // one client access starting on a falling edge
   task automatic run_access(input int p, input logic wr, input int addr,
         input logic [data_w-1:0] wdata);
      int waited;
      waited = 0;
      drive_port(p, 1'b1, wr, addr, wdata);
      do begin
         @(negedge main_clk);
         waited++;
      end while (!done_v[p] && waited < done_limit);
      if (!done_v[p]) begin
         timeout_errors++;
         $display("%0t no done from %s within %0d cycles", $time, port_name(p), done_limit);
      end
      @(negedge main_clk);                     // drop req the cycle after the pulse
      drive_port(p, 1'b0, 1'b0, 0, '0);
      @(negedge main_clk);
   endtask

   task automatic print_counts();
      $display("errors: value %0d protocol %0d timing %0d timeout %0d", value_errors,
         protocol_errors, timing_errors, timeout_errors);
   endtask

   initial begin
      logic [sdram_aw-1:0] pool [8];          // few addresses, so writes overlap
      logic [vram_aw-1:0] vaddr [n_video];
      int k;
      void'($urandom(rand_seed));
      main_clk = 1'b0;
      reset = 1'b1;
      race_mode = 1'b0;
      for (int p = 0; p < 3; p++) begin
         drive_port(p, 1'b0, 1'b0, 0, '0);
      end
      repeat (8) @(negedge main_clk);
      reset = 1'b0;
      while (!calib_done) @(negedge main_clk);
      for (int i = 0; i < 8; i++) begin
         pool[i] = sdram_aw'($urandom);
      end
      for (int i = 0; i < 2 * n_rand; i++) begin
         k = $urandom_range(0, 7);
         run_access(0, i < n_rand, int'(pool[k]), $urandom);   // writes, then reads
      end
      for (int i = 0; i < n_video; i++) begin
         vaddr[i] = vram_aw'($urandom);
         run_access(1, 1'b1, int'(vaddr[i]), $urandom);
         run_access(2, 1'b0, int'(vaddr[i]), '0);
         run_access(1, 1'b0, int'(vaddr[i]), '0);
      end
      // reads first, then writes next to a display read of another word
      for (int r = 0; r < n_race; r++) begin
         race_mode = 1'b1;
         fork
            run_access(0, r[0], int'(pool[r]), $urandom);
            run_access(1, r[0], int'(vaddr[r + 1]) ^ r, $urandom);
            run_access(2, 1'b0, int'(vaddr[r + 1]), '0);
         join
         race_mode = 1'b0;
         @(negedge main_clk);                  // completion record clears between races
      end
      repeat (4) @(negedge main_clk);
      print_counts();
      if (value_errors + protocol_errors + timing_errors + timeout_errors == 0) begin
         $display("sim passed");
      end else begin
         $display("sim failed");
      end
      $finish;
   end

   // bound on the whole run
   initial begin
      repeat (watchdog_cycles) @(posedge main_clk);
      $display("%0t watchdog expired after %0d cycles, run did not finish", $time,
         watchdog_cycles);
      print_counts();
      $display("sim failed");
      $finish;
   end

endmodule

//--- logic/memory_subsystem_top.sv
// memory side top level, sequencer, arbiter, bank pipeline and return stage
`timescale 1ns/1ns

module memory_subsystem_top import mem_pkg::*; #(
   parameter int SDRAM_AW = 12,        // 22 on the board
   parameter int VRAM_AW = 10,         // 15 on the board
   parameter int ACCESS_LAT = 3,
   parameter int CALIB_CYCLES = 64,
   localparam int addr_w = issue_aw(SDRAM_AW, VRAM_AW)
) (
   input  logic main_clk,
   input  logic reset,
   output logic calib_done,
   // cpu main memory
   input  logic sdram_req,
   input  logic sdram_write,
   input  logic [SDRAM_AW-1:0] sdram_addr,
   input  logic [data_w-1:0] sdram_data_in,
   output logic [data_w-1:0] sdram_data_out,
   output logic sdram_ready,
   output logic sdram_done,
   // cpu video memory
   input  logic vram_cpu_req,
   input  logic vram_cpu_write,
   input  logic [VRAM_AW-1:0] vram_cpu_addr,
   input  logic [data_w-1:0] vram_cpu_data_in,
   output logic [data_w-1:0] vram_cpu_data_out,
   output logic vram_cpu_ready,
   output logic vram_cpu_done,
   // display fetch
   input  logic vram_vga_req,
   input  logic [VRAM_AW-1:0] vram_vga_addr,
   output logic [data_w-1:0] vram_vga_data_out,
   output logic vram_vga_ready
);

   logic mem_reset;
   logic issue_valid, issue_write;           // arbiter to banks
   port_id_t issue_port;
   logic [addr_w-1:0] issue_addr;
   logic [data_w-1:0] issue_data;
   logic rd_valid;                           // banks to return stage
   port_id_t rd_port;
   logic [data_w-1:0] rd_data;
   logic retire_valid;                       // return stage back to arbiter
   port_id_t retire_port;

   reset_sequencer #(.CALIB_CYCLES(CALIB_CYCLES)) seq_i (
      .main_clk(main_clk), .reset(reset), .mem_reset(mem_reset), .calib_done(calib_done));

   port_arbiter #(.SDRAM_AW(SDRAM_AW), .VRAM_AW(VRAM_AW)) arb_i (
      .main_clk(main_clk), .mem_reset(mem_reset), .calib_done(calib_done),
      .sdram_req(sdram_req), .sdram_write(sdram_write), .sdram_addr(sdram_addr),
      .sdram_data_in(sdram_data_in), .sdram_ready(sdram_ready),
      .vram_cpu_req(vram_cpu_req), .vram_cpu_write(vram_cpu_write),
      .vram_cpu_addr(vram_cpu_addr), .vram_cpu_data_in(vram_cpu_data_in),
      .vram_cpu_ready(vram_cpu_ready),
      .vram_vga_req(vram_vga_req), .vram_vga_addr(vram_vga_addr),
      .retire_valid(retire_valid), .retire_port(retire_port),
      .issue_valid(issue_valid), .issue_port(issue_port), .issue_write(issue_write),
      .issue_addr(issue_addr), .issue_data(issue_data));

   bank_access #(.SDRAM_AW(SDRAM_AW), .VRAM_AW(VRAM_AW), .ACCESS_LAT(ACCESS_LAT)) bank_i (
      .main_clk(main_clk), .mem_reset(mem_reset),
      .issue_valid(issue_valid), .issue_port(issue_port), .issue_write(issue_write),
      .issue_addr(issue_addr), .issue_data(issue_data),
      .rd_valid(rd_valid), .rd_port(rd_port), .rd_data(rd_data));

   done_return ret_i (
      .main_clk(main_clk), .mem_reset(mem_reset),
      .rd_valid(rd_valid), .rd_port(rd_port), .rd_data(rd_data),
      .sdram_data_out(sdram_data_out), .sdram_done(sdram_done),
      .vram_cpu_data_out(vram_cpu_data_out), .vram_cpu_done(vram_cpu_done),
      .vram_vga_data_out(vram_vga_data_out), .vram_vga_ready(vram_vga_ready),
      .retire_valid(retire_valid), .retire_port(retire_port));

endmodule

//--- logic/done_return.sv
// result stage, routes pipeline output to per-port data, done pulses and retire
`timescale 1ns/1ns

module done_return import mem_pkg::*; (
   input  logic main_clk,
   input  logic mem_reset,
   // from bank_access
   input  logic rd_valid,
   input  port_id_t rd_port,
   input  logic [data_w-1:0] rd_data,
   // sdram client
   output logic [data_w-1:0] sdram_data_out,
   output logic sdram_done,
   // video cpu client
   output logic [data_w-1:0] vram_cpu_data_out,
   output logic vram_cpu_done,
   // display client whose ready doubles as done
   output logic [data_w-1:0] vram_vga_data_out,
   output logic vram_vga_ready,
   // back to port_arbiter
   output logic retire_valid,
   output port_id_t retire_port
);

   logic sdram_hit, cpu_hit, vga_hit;

   ////////////////////////////////////////
   // port decode
   ////////////////////////////////////////

   assign sdram_hit = rd_valid && (rd_port == port_sdram);
   assign cpu_hit = rd_valid && (rd_port == port_vram_cpu);
   assign vga_hit = rd_valid && (rd_port == port_vram_vga);

   ////////////////////////////////////////
   // registered returns
   ////////////////////////////////////////

   // one cycle pulses with data held until the port's next done
   always_ff @(posedge main_clk) begin
      if (mem_reset) begin
         sdram_done <= 1'b0;
         vram_cpu_done <= 1'b0;
         vram_vga_ready <= 1'b0;
         sdram_data_out <= '0;
         vram_cpu_data_out <= '0;
         vram_vga_data_out <= '0;
         retire_valid <= 1'b0;
      end else begin
         sdram_done <= sdram_hit;
         vram_cpu_done <= cpu_hit;
         vram_vga_ready <= vga_hit;
         if (sdram_hit) begin
            sdram_data_out <= rd_data;      // zero after a write
         end
         if (cpu_hit) begin
            vram_cpu_data_out <= rd_data;
         end
         if (vga_hit) begin
            vram_vga_data_out <= rd_data;
         end
         retire_valid <= rd_valid;          // same cycle as the done pulse
      end
   end

   // tag only matters alongside retire_valid
   always_ff @(posedge main_clk) begin
      if (rd_valid) begin
         retire_port <= rd_port;
      end
   end

endmodule

//--- logic/bank_access.sv
// execute stage, main and video storage arrays behind a fixed latency pipeline
`timescale 1ns/1ns

module bank_access import mem_pkg::*; #(
   parameter int SDRAM_AW = 12,
   parameter int VRAM_AW = 10,
   parameter int ACCESS_LAT = 3,        // issue to rd_valid, cycles
   localparam int addr_w = issue_aw(SDRAM_AW, VRAM_AW)
) (
   input  logic main_clk,
   input  logic mem_reset,
   input  logic issue_valid,
   input  port_id_t issue_port,
   input  logic issue_write,
   input  logic [addr_w-1:0] issue_addr,
   input  logic [data_w-1:0] issue_data,
   output logic rd_valid,
   output port_id_t rd_port,
   output logic [data_w-1:0] rd_data
);

   logic [data_w-1:0] main_mem [2**SDRAM_AW];    // cpu main memory
   logic [data_w-1:0] video_mem [2**VRAM_AW];    // shared by vram_cpu and vram_vga

   logic is_main;
   logic [SDRAM_AW-1:0] main_idx;
   logic [VRAM_AW-1:0] video_idx;
   logic [data_w-1:0] rd_word;

   logic [ACCESS_LAT-1:0] pipe_valid;
   port_id_t pipe_port [ACCESS_LAT];
   logic [data_w-1:0] pipe_data [ACCESS_LAT];

   ////////////////////////////////////////
   // bank select and storage
   ////////////////////////////////////////

   assign is_main = (issue_port == port_sdram);   // both vram ports land in video_mem
   assign main_idx = issue_addr[SDRAM_AW-1:0];
   assign video_idx = issue_addr[VRAM_AW-1:0];

   assign rd_word = is_main ? main_mem[main_idx] : video_mem[video_idx];

   // writes land at issue time, later reads see them
   always_ff @(posedge main_clk) begin
      if (issue_valid && issue_write) begin
         if (is_main) begin
            main_mem[main_idx] <= issue_data;
         end else begin
            video_mem[video_idx] <= issue_data;
         end
      end
   end

   ////////////////////////////////////////
   // latency pipeline
   ////////////////////////////////////////

   always_ff @(posedge main_clk) begin
      if (mem_reset) begin
         pipe_valid <= '0;
      end else begin
         pipe_valid[0] <= issue_valid;    // writes go down too so they retire
         for (int i = 1; i < ACCESS_LAT; i++) begin
            pipe_valid[i] <= pipe_valid[i-1];
         end
      end
   end

   // tag and data take one slot per cycle of latency
   always_ff @(posedge main_clk) begin
      pipe_port[0] <= issue_port;
      pipe_data[0] <= issue_write ? '0 : rd_word;   // sampled once at issue
      for (int i = 1; i < ACCESS_LAT; i++) begin
         pipe_port[i] <= pipe_port[i-1];
         pipe_data[i] <= pipe_data[i-1];
      end
   end

   assign rd_valid = pipe_valid[ACCESS_LAT-1];
   assign rd_port = pipe_port[ACCESS_LAT-1];
   assign rd_data = pipe_data[ACCESS_LAT-1];

   // display side has no write path at all
   vga_read_only_a: assert property (@(posedge main_clk) disable iff (mem_reset)
      issue_valid && issue_port == port_vram_vga |-> !issue_write);

endmodule

//--- logic/port_arbiter.sv
// decode stage, fixed priority grant of three ports with in-flight tracking
`timescale 1ns/1ns

module port_arbiter import mem_pkg::*; #(
   parameter int SDRAM_AW = 12,
   parameter int VRAM_AW = 10,
   localparam int addr_w = issue_aw(SDRAM_AW, VRAM_AW)
) (
   input  logic main_clk,
   input  logic mem_reset,
   input  logic calib_done,
   // sdram port
   input  logic sdram_req,
   input  logic sdram_write,
   input  logic [SDRAM_AW-1:0] sdram_addr,
   input  logic [data_w-1:0] sdram_data_in,
   output logic sdram_ready,
   // video cpu port
   input  logic vram_cpu_req,
   input  logic vram_cpu_write,
   input  logic [VRAM_AW-1:0] vram_cpu_addr,
   input  logic [data_w-1:0] vram_cpu_data_in,
   output logic vram_cpu_ready,
   // display port, reads only
   input  logic vram_vga_req,
   input  logic [VRAM_AW-1:0] vram_vga_addr,
   // retire from done_return
   input  logic retire_valid,
   input  port_id_t retire_port,
   // issue to bank_access
   output logic issue_valid,
   output port_id_t issue_port,
   output logic issue_write,
   output logic [addr_w-1:0] issue_addr,
   output logic [data_w-1:0] issue_data
);

   logic [n_ports-1:0] inflight;       // one outstanding access per port
   logic [n_ports-1:0] grant_vec;      // indexed by port tag
   logic [n_ports-1:0] retire_mask;
   logic vga_grant, sdram_grant, cpu_grant;

   ////////////////////////////////////////
   // ready and grant
   ////////////////////////////////////////

   assign sdram_ready = calib_done && !inflight[port_sdram];
   assign vram_cpu_ready = calib_done && !inflight[port_vram_cpu];

   // display first, then sdram, then vram_cpu
   assign vga_grant = vram_vga_req && calib_done && !inflight[port_vram_vga];
   assign sdram_grant = sdram_req && sdram_ready && !vga_grant;
   assign cpu_grant = vram_cpu_req && vram_cpu_ready && !vga_grant && !sdram_grant;

   always_comb begin
      grant_vec = '0;
      grant_vec[port_vram_vga] = vga_grant;
      grant_vec[port_sdram] = sdram_grant;
      grant_vec[port_vram_cpu] = cpu_grant;
   end

   assign retire_mask = retire_valid ? (n_ports'(1) << retire_port) : '0;

   ////////////////////////////////////////
   // in-flight and issue
   ////////////////////////////////////////

   always_ff @(posedge main_clk) begin
      if (mem_reset) begin
         inflight <= '0;
         issue_valid <= 1'b0;
      end else begin
         inflight <= (inflight & ~retire_mask) | grant_vec;   // set on grant, clear on retire
         issue_valid <= |grant_vec;                            // at most one bit set
      end
   end

   // issue word with the narrower address zero extended
   always_ff @(posedge main_clk) begin
      if (vga_grant) begin
         issue_port <= port_vram_vga;
         issue_write <= 1'b0;
         issue_addr <= addr_w'(vram_vga_addr);
         issue_data <= '0;                 // no write data on the display side
      end else if (sdram_grant) begin
         issue_port <= port_sdram;
         issue_write <= sdram_write;
         issue_addr <= addr_w'(sdram_addr);
         issue_data <= sdram_data_in;
      end else if (cpu_grant) begin
         issue_port <= port_vram_cpu;
         issue_write <= vram_cpu_write;
         issue_addr <= addr_w'(vram_cpu_addr);
         issue_data <= vram_cpu_data_in;
      end
   end

   // a retire always closes an access that is still open
   issue_once_a: assert property (@(posedge main_clk) disable iff (mem_reset)
      retire_valid |-> inflight[retire_port]);

   issue_calib_a: assert property (@(posedge main_clk) disable iff (mem_reset)
      issue_valid |-> calib_done);

endmodule

//--- logic/reset_sequencer.sv
// memory reset stretcher and calibration wait counter with sticky calib_done
`timescale 1ns/1ns

module reset_sequencer import mem_pkg::*; #(
   parameter int CALIB_CYCLES = 64     // calibration wait after mem_reset drops
) (
   input  logic main_clk,
   input  logic reset,                 // board reset, sync, active high
   output logic mem_reset,             // stretched reset to the three stages
   output logic calib_done             // memory usable, sticky until reset
);

   localparam int stretch_w = $clog2(reset_stretch + 1);
   localparam int calib_w = $clog2(CALIB_CYCLES + 1);

   logic [stretch_w-1:0] stretch_cnt;   // edges seen with reset low
   logic [calib_w-1:0] calib_cnt;       // edges seen with mem_reset low

   ////////////////////////////////////////
   // reset stretch
   ////////////////////////////////////////

   // mem_reset drops on the 4th edge after reset goes away
   always_ff @(posedge main_clk) begin
      if (reset) begin
         stretch_cnt <= '0;
         mem_reset <= 1'b1;
      end else if (mem_reset) begin
         if (stretch_cnt == stretch_w'(reset_stretch - 1)) begin
            mem_reset <= 1'b0;   // last stretch cycle
         end
         stretch_cnt <= stretch_cnt + 1'b1;
      end
   end

   ////////////////////////////////////////
   // calibration wait
   ////////////////////////////////////////

   // counted wait stands in for phy calibration
   always_ff @(posedge main_clk) begin
      if (reset) begin
         calib_cnt <= '0;
         calib_done <= 1'b0;   // falls together with board reset
      end else if (mem_reset) begin
         calib_cnt <= '0;      // hold off while still stretching
      end else if (!calib_done) begin
         if (calib_cnt == calib_w'(CALIB_CYCLES - 1)) begin
            calib_done <= 1'b1;
         end else begin
            calib_cnt <= calib_cnt + 1'b1;
         end
      end
   end

   // flag rises only once the stages were already released a full wait earlier
   calib_after_reset_a: assert property (@(posedge main_clk)
      $rose(calib_done) |-> !mem_reset && $past(!mem_reset, CALIB_CYCLES));

endmodule

//--- logic/mem_pkg.sv
// data width, port tags, reset stretch length and issue address helper
package mem_pkg;

   ////////////////////////////////////////
   // data path
   ////////////////////////////////////////

   localparam int data_w = 32;      // every client word, cpu and display alike
   localparam int n_ports = 3;      // sdram, vram_cpu, vram_vga

   ////////////////////////////////////////
   // port tags
   ////////////////////////////////////////

   // tag rides with each access from grant to retire
   typedef logic [1:0] port_id_t;

   localparam port_id_t port_vram_vga = 2'd0;   // display fetch, top priority
   localparam port_id_t port_sdram = 2'd1;      // cpu main memory
   localparam port_id_t port_vram_cpu = 2'd2;   // cpu side of video memory
   // 2'd3 never issued

   ////////////////////////////////////////
   // sequencing
   ////////////////////////////////////////

   // cycles mem_reset outlives the board reset
   localparam int reset_stretch = 4;

   // one address bus into the banks as wide as the larger store
   function automatic int issue_aw(input int main_aw, input int video_aw);
      return (main_aw > video_aw) ? main_aw : video_aw;
   endfunction

endpackage
